//--- hw/vtu_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vertex transform unit configuration
// Widths and constants shared by the
// matrix registers and the pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VTU_CFG_SVH
`define VTU_CFG_SVH

// Width of one vector or matrix component
`define VTU_DATA_W 32
// Q16.16 fraction bits
`define VTU_FRAC_BITS 16
// 4x4 matrix words
`define VTU_MAT_ENTRIES 16
// AXI4-Lite byte address, 16 words of 4 bytes
`define VTU_AXIL_ADDR_W 6
// Float exponent for a magnitude with no leading zeros (127 + 31 - 16)
`define VTU_FP_EXP_K 142
// Headroom for summing four products
`define VTU_ACC_GUARD 2

`endif

//--- hw/vtu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vertex transform unit types
// Fixed-point, float and bus vectors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vtu_cfg.svh"

package vtu_pkg;

    // Datapath values
    typedef logic signed [`VTU_DATA_W-1:0] q16_t;
    typedef logic signed [2*`VTU_DATA_W-1:0] product_t;
    typedef logic signed [2*`VTU_DATA_W+`VTU_ACC_GUARD-1:0] acc_t;
    typedef logic [`VTU_DATA_W-1:0] fp32_t;

    // Four components, x in the low word
    typedef logic [4*`VTU_DATA_W-1:0] vec_t;
    // Row-major matrix, entry 0 lowest
    typedef logic [`VTU_MAT_ENTRIES*`VTU_DATA_W-1:0] mat_flat_t;

    // AXI4-Lite fields
    typedef logic [`VTU_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`VTU_DATA_W-1:0] axil_data_t;
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t resp_okay = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

endpackage

//--- hw/vtu_fixed_to_fp32.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Q16.16 to float32 converter
// Combinational, truncating mantissa
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vtu_cfg.svh"

module vtu_fixed_to_fp32 (
    input  vtu_pkg::q16_t  i_fixed,
    output vtu_pkg::fp32_t o_float
);
    logic        sign_w;
    logic [31:0] mag;
    logic [4:0]  lz;
    logic [31:0] norm;
    logic [7:0]  exp_w;
    logic        is_zero;

    // Leading zeros of a nonzero word, halving the window each level
    function automatic logic [4:0] count_lz(input logic [31:0] x);
        logic [31:0] v;
        logic [4:0]  n;
        v = x;
        n = '0;
        if (v[31:16] == '0) begin
            n[4] = 1'b1;
            v = v << 16;
        end
        if (v[31:24] == '0) begin
            n[3] = 1'b1;
            v = v << 8;
        end
        if (v[31:28] == '0) begin
            n[2] = 1'b1;
            v = v << 4;
        end
        if (v[31:30] == '0) begin
            n[1] = 1'b1;
            v = v << 2;
        end
        n[0] = ~v[31];
        return n;
    endfunction

    assign sign_w  = i_fixed[31];
    assign mag     = sign_w ? (~i_fixed + 32'd1) : i_fixed;
    assign is_zero = (mag == '0);
    assign lz      = count_lz(mag);

    // Leading one lands in bit 31 and is dropped as the hidden bit
    assign norm  = mag << lz;
    assign exp_w = 8'(`VTU_FP_EXP_K) - {3'b000, lz};

    assign o_float = is_zero ? '0 : {sign_w, exp_w, norm[30:8]};

endmodule

//--- hw/vtu_matrix_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix register file
// AXI4-Lite write-only slave holding the
// sixteen Q16.16 transform entries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vtu_cfg.svh"

module vtu_matrix_regs (
    input  logic                aclk,
    input  logic                aresetn,
    input  vtu_pkg::axil_addr_t i_s_axi_awaddr,
    input  logic                i_s_axi_awvalid,
    output logic                o_s_axi_awready,
    input  vtu_pkg::axil_data_t i_s_axi_wdata,
    input  logic                i_s_axi_wvalid,
    output logic                o_s_axi_wready,
    output vtu_pkg::axi_resp_t  o_s_axi_bresp,
    output logic                o_s_axi_bvalid,
    input  logic                i_s_axi_bready,
    output vtu_pkg::mat_flat_t  o_mat_flat
);
    import vtu_pkg::*;

    localparam int ADDR_LSB = $clog2(`VTU_DATA_W / 8);

    axil_data_t mat_q [`VTU_MAT_ENTRIES];

    logic       awready_q;
    logic       wready_q;
    logic       bvalid_q;
    logic       aw_held_q;
    logic       w_held_q;
    axil_addr_t awaddr_q;
    axil_data_t wdata_q;

    logic                                aw_take;
    logic                                w_take;
    logic [`VTU_AXIL_ADDR_W-ADDR_LSB-1:0] aw_word;

    assign aw_take = awready_q & i_s_axi_awvalid;
    assign w_take  = wready_q & i_s_axi_wvalid;
    assign aw_word = awaddr_q[`VTU_AXIL_ADDR_W-1:ADDR_LSB];

    // Address and data beats
    always_ff @(posedge aclk) begin
        if (aw_take)
            awaddr_q <= i_s_axi_awaddr;
        if (w_take)
            wdata_q <= i_s_axi_wdata;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < `VTU_MAT_ENTRIES; i++)
                mat_q[i] <= '0;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            // Ready again once the channel is free and no response blocks
            awready_q <= !(aw_held_q || aw_take) && (!bvalid_q || i_s_axi_bready);
            wready_q  <= !(w_held_q || w_take) && (!bvalid_q || i_s_axi_bready);

            if (aw_take)
                aw_held_q <= 1'b1;
            if (w_take)
                w_held_q <= 1'b1;

            // Commit once both halves are in
            if (aw_held_q && w_held_q && !bvalid_q) begin
                mat_q[aw_word] <= wdata_q;
                bvalid_q  <= 1'b1;
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
            end else if (bvalid_q && i_s_axi_bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    for (genvar g = 0; g < `VTU_MAT_ENTRIES; g++) begin : g_flat
        assign o_mat_flat[g*`VTU_DATA_W +: `VTU_DATA_W] = mat_q[g];
    end

    assign o_s_axi_awready = awready_q;
    assign o_s_axi_wready  = wready_q;
    assign o_s_axi_bvalid  = bvalid_q;
    assign o_s_axi_bresp   = resp_okay;

endmodule

//--- hw/vtu_mac_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector multiply-accumulate
// Three registered stages that turn a
// vector into four 66-bit row sums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vtu_cfg.svh"

module vtu_mac_array (
    input  logic               aclk,
    input  logic               aresetn,
    input  vtu_pkg::mat_flat_t i_mat_flat,
    input  vtu_pkg::vec_t      i_vec,
    input  logic               i_valid,
    input  logic               i_last,
    output logic               o_ready,
    output vtu_pkg::acc_t      o_sum_x,
    output vtu_pkg::acc_t      o_sum_y,
    output vtu_pkg::acc_t      o_sum_z,
    output vtu_pkg::acc_t      o_sum_w,
    output logic               o_valid,
    output logic               o_last,
    input  logic               i_ready
);
    import vtu_pkg::*;

    q16_t mat_w [16];
    q16_t comp_w [4];

    // S1 products, S2a column pairs, S2b row sums
    product_t prod_q [16];
    acc_t     pair_q [8];
    acc_t     sum_q [4];

    logic s1_valid_q, s1_last_q;
    logic s2a_valid_q, s2a_last_q;
    logic s2b_valid_q, s2b_last_q;

    logic s1_ready;
    logic s2a_ready;
    logic s2b_ready;

    for (genvar g = 0; g < 16; g++) begin : g_mat
        assign mat_w[g] = i_mat_flat[g*`VTU_DATA_W +: `VTU_DATA_W];
    end

    for (genvar g = 0; g < 4; g++) begin : g_comp
        assign comp_w[g] = i_vec[g*`VTU_DATA_W +: `VTU_DATA_W];
    end

    // A stage takes new data when empty or when it drains downstream
    assign s2b_ready = ~s2b_valid_q | i_ready;
    assign s2a_ready = ~s2a_valid_q | s2b_ready;
    assign s1_ready  = ~s1_valid_q | s2a_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s1_valid_q  <= 1'b0;
            s1_last_q   <= 1'b0;
            s2a_valid_q <= 1'b0;
            s2a_last_q  <= 1'b0;
            s2b_valid_q <= 1'b0;
            s2b_last_q  <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid_q <= i_valid;
                s1_last_q  <= i_last;
            end
            if (s2a_ready) begin
                s2a_valid_q <= s1_valid_q;
                s2a_last_q  <= s1_last_q;
            end
            if (s2b_ready) begin
                s2b_valid_q <= s2a_valid_q;
                s2b_last_q  <= s2a_last_q;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (s1_ready && i_valid) begin
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++)
                    prod_q[r*4+c] <= product_t'(mat_w[r*4+c]) * product_t'(comp_w[c]);
        end
        if (s2a_ready && s1_valid_q) begin
            for (int r = 0; r < 4; r++) begin
                pair_q[2*r]   <= acc_t'(prod_q[4*r])   + acc_t'(prod_q[4*r+1]);
                pair_q[2*r+1] <= acc_t'(prod_q[4*r+2]) + acc_t'(prod_q[4*r+3]);
            end
        end
        if (s2b_ready && s2a_valid_q) begin
            for (int r = 0; r < 4; r++)
                sum_q[r] <= pair_q[2*r] + pair_q[2*r+1];
        end
    end

    assign o_ready = s1_ready;
    assign o_valid = s2b_valid_q;
    assign o_last  = s2b_last_q;
    assign o_sum_x = sum_q[0];
    assign o_sum_y = sum_q[1];
    assign o_sum_z = sum_q[2];
    assign o_sum_w = sum_q[3];

endmodule

//--- hw/vtu_output_stages.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output stages of the transform pipe
// Shift and clamp each row sum, then
// register its float32 form as a beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vtu_cfg.svh"

module vtu_output_stages (
    input  logic          aclk,
    input  logic          aresetn,
    input  vtu_pkg::acc_t i_sum_x,
    input  vtu_pkg::acc_t i_sum_y,
    input  vtu_pkg::acc_t i_sum_z,
    input  vtu_pkg::acc_t i_sum_w,
    input  logic          i_valid,
    input  logic          i_last,
    output logic          o_ready,
    output vtu_pkg::vec_t o_m_axis_tdata,
    output logic          o_m_axis_tvalid,
    output logic          o_m_axis_tlast,
    input  logic          i_m_axis_tready
);
    import vtu_pkg::*;

    localparam q16_t Q16_MAX = q16_t'({1'b0, {(`VTU_DATA_W-1){1'b1}}});
    localparam q16_t Q16_MIN = q16_t'({1'b1, {(`VTU_DATA_W-1){1'b0}}});

    acc_t  sum_w [4];
    q16_t  fixed_q [4];
    fp32_t float_w [4];
    fp32_t float_q [4];

    logic s3_valid_q, s3_last_q;
    logic s4_valid_q, s4_last_q;
    logic s3_ready;
    logic s4_ready;

    // Back to Q16.16 with saturation
    function automatic q16_t shift_sat(input acc_t acc);
        acc_t sh;
        sh = acc >>> `VTU_FRAC_BITS;
        if (sh > acc_t'(Q16_MAX))
            return Q16_MAX;
        if (sh < acc_t'(Q16_MIN))
            return Q16_MIN;
        return sh[`VTU_DATA_W-1:0];
    endfunction

    assign sum_w[0] = i_sum_x;
    assign sum_w[1] = i_sum_y;
    assign sum_w[2] = i_sum_z;
    assign sum_w[3] = i_sum_w;

    assign s4_ready = ~s4_valid_q | i_m_axis_tready;
    assign s3_ready = ~s3_valid_q | s4_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s3_valid_q <= 1'b0;
            s3_last_q  <= 1'b0;
            s4_valid_q <= 1'b0;
            s4_last_q  <= 1'b0;
        end else begin
            if (s3_ready) begin
                s3_valid_q <= i_valid;
                s3_last_q  <= i_last;
            end
            if (s4_ready) begin
                s4_valid_q <= s3_valid_q;
                s4_last_q  <= s3_last_q;
            end
        end
    end

    for (genvar g = 0; g < 4; g++) begin : g_conv
        vtu_fixed_to_fp32 u_conv (
            .i_fixed (fixed_q[g]),
            .o_float (float_w[g])
        );
    end

    always_ff @(posedge aclk) begin
        if (s3_ready && i_valid) begin
            for (int i = 0; i < 4; i++)
                fixed_q[i] <= shift_sat(sum_w[i]);
        end
        if (s4_ready && s3_valid_q) begin
            for (int i = 0; i < 4; i++)
                float_q[i] <= float_w[i];
        end
    end

    assign o_ready         = s3_ready;
    assign o_m_axis_tvalid = s4_valid_q;
    assign o_m_axis_tlast  = s4_last_q;
    assign o_m_axis_tdata  = {float_q[3], float_q[2], float_q[1], float_q[0]};

endmodule

//--- hw/vertex_transform_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vertex transform unit
// AXI4-Lite matrix load, Q16.16 vector
// stream in, float32 vector stream out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vertex_transform_unit (
    input  logic                aclk,
    input  logic                aresetn,
    input  vtu_pkg::axil_addr_t i_s_axi_awaddr,
    input  logic                i_s_axi_awvalid,
    output logic                o_s_axi_awready,
    input  vtu_pkg::axil_data_t i_s_axi_wdata,
    input  logic                i_s_axi_wvalid,
    output logic                o_s_axi_wready,
    output vtu_pkg::axi_resp_t  o_s_axi_bresp,
    output logic                o_s_axi_bvalid,
    input  logic                i_s_axi_bready,
    input  vtu_pkg::vec_t       i_s_axis_tdata,
    input  logic                i_s_axis_tvalid,
    output logic                o_s_axis_tready,
    input  logic                i_s_axis_tlast,
    output vtu_pkg::vec_t       o_m_axis_tdata,
    output logic                o_m_axis_tvalid,
    input  logic                i_m_axis_tready,
    output logic                o_m_axis_tlast
);
    import vtu_pkg::*;

    mat_flat_t mat_flat;
    acc_t      sum_x, sum_y, sum_z, sum_w;
    logic      sum_valid;
    logic      sum_last;
    logic      sum_ready;

    vtu_matrix_regs u_matrix_regs (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_s_axi_awaddr  (i_s_axi_awaddr),
        .i_s_axi_awvalid (i_s_axi_awvalid),
        .o_s_axi_awready (o_s_axi_awready),
        .i_s_axi_wdata   (i_s_axi_wdata),
        .i_s_axi_wvalid  (i_s_axi_wvalid),
        .o_s_axi_wready  (o_s_axi_wready),
        .o_s_axi_bresp   (o_s_axi_bresp),
        .o_s_axi_bvalid  (o_s_axi_bvalid),
        .i_s_axi_bready  (i_s_axi_bready),
        .o_mat_flat      (mat_flat)
    );

    vtu_mac_array u_mac_array (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_mat_flat (mat_flat),
        .i_vec      (i_s_axis_tdata),
        .i_valid    (i_s_axis_tvalid),
        .i_last     (i_s_axis_tlast),
        .o_ready    (o_s_axis_tready),
        .o_sum_x    (sum_x),
        .o_sum_y    (sum_y),
        .o_sum_z    (sum_z),
        .o_sum_w    (sum_w),
        .o_valid    (sum_valid),
        .o_last     (sum_last),
        .i_ready    (sum_ready)
    );

    vtu_output_stages u_output_stages (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_sum_x         (sum_x),
        .i_sum_y         (sum_y),
        .i_sum_z         (sum_z),
        .i_sum_w         (sum_w),
        .i_valid         (sum_valid),
        .i_last          (sum_last),
        .o_ready         (sum_ready),
        .o_m_axis_tdata  (o_m_axis_tdata),
        .o_m_axis_tvalid (o_m_axis_tvalid),
        .o_m_axis_tlast  (o_m_axis_tlast),
        .i_m_axis_tready (i_m_axis_tready)
    );

endmodule

//--- bench/vtu_stream_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks for the transform unit
// Output stream and AXI4-Lite B channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vtu_stream_chk (
    input logic          aclk,
    input logic          aresetn,
    input vtu_pkg::vec_t i_tdata,
    input logic          i_tvalid,
    input logic          i_tready,
    input logic          i_tlast,
    input logic          i_bvalid,
    input logic          i_bready
);
    int unsigned fail_count = 0;

    // Stalled beat keeps data and last
    a_hold_beat: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_tvalid && !i_tready |=> i_tvalid && $stable(i_tdata) && $stable(i_tlast)
    ) else begin
        $error("output beat changed while stalled");
        fail_count++;
    end

    a_hold_bvalid: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_bvalid && !i_bready |=> i_bvalid
    ) else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    // Reset empties the output stage
    a_reset_idle: assert property (
        @(posedge aclk) !aresetn |=> !i_tvalid
    ) else begin
        $error("output tvalid high during reset");
        fail_count++;
    end

endmodule

bind vertex_transform_unit vtu_stream_chk u_stream_chk (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .i_tdata  (o_m_axis_tdata),
    .i_tvalid (o_m_axis_tvalid),
    .i_tready (i_m_axis_tready),
    .i_tlast  (o_m_axis_tlast),
    .i_bvalid (o_s_axi_bvalid),
    .i_bready (i_s_axi_bready)
);

//--- bench/tb_vertex_transform_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vertex transform unit testbench
// Directed tests against a Q16.16 model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vtu_cfg.svh"

module tb_vertex_transform_unit;
    import vtu_pkg::*;

    localparam time CLK_PERIOD = 40ns;
    localparam time DRV_DLY = 2ns;
    localparam int TIMEOUT = 400;
    localparam logic [31:0] SEED = 32'hbe3f_16f7;

    logic       aclk = 1'b0;
    logic       aresetn;
    axil_addr_t awaddr;
    axil_data_t wdata;
    axi_resp_t  bresp;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    vec_t       s_tdata, m_tdata;
    logic       s_tvalid, s_tready, s_tlast, m_tvalid, m_tready, m_tlast;
    logic       stall_en;

    q16_t mat [16];
    vec_t exp_data_q[$], got_data_q[$];
    logic exp_last_q[$], got_last_q[$];
    int   err_cnt, test_cnt, fail_cnt;

    vertex_transform_unit DUT (
        .aclk (aclk), .aresetn (aresetn),
        .i_s_axi_awaddr (awaddr), .i_s_axi_awvalid (awvalid), .o_s_axi_awready (awready),
        .i_s_axi_wdata (wdata), .i_s_axi_wvalid (wvalid), .o_s_axi_wready (wready),
        .o_s_axi_bresp (bresp), .o_s_axi_bvalid (bvalid), .i_s_axi_bready (bready),
        .i_s_axis_tdata (s_tdata), .i_s_axis_tvalid (s_tvalid),
        .o_s_axis_tready (s_tready), .i_s_axis_tlast (s_tlast),
        .o_m_axis_tdata (m_tdata), .o_m_axis_tvalid (m_tvalid),
        .i_m_axis_tready (m_tready), .o_m_axis_tlast (m_tlast)
    );

    initial begin
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Random sink stalls when enabled
    always @(posedge aclk) begin
        #DRV_DLY;
        m_tready = stall_en ? 1'($urandom) : 1'b1;
    end

    // Outputs are steady between the falling and the next rising edge
    always @(negedge aclk) begin
        if (aresetn && m_tvalid && m_tready) begin
            got_data_q.push_back(m_tdata);
            got_last_q.push_back(m_tlast);
        end
    end

    task automatic check_fp32(input string name, input fp32_t got, input fp32_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        err_cnt++;
    endtask

    // Float32 by normalizing one bit at a time with a truncated mantissa
    function automatic fp32_t to_fp32(input q16_t q);
        logic [31:0] mag;
        int          e;
        if (q == 0)
            return '0;
        mag = q[31] ? -q : q;
        e = `VTU_FP_EXP_K;
        while (!mag[31]) begin
            mag = mag << 1;
            e--;
        end
        return {q[31], 8'(e), mag[30:8]};
    endfunction

    function automatic vec_t model_out(input vec_t v);
        vec_t r;
        acc_t sum;
        acc_t sh;
        q16_t c;
        for (int row = 0; row < 4; row++) begin
            sum = '0;
            for (int col = 0; col < 4; col++)
                sum += acc_t'(mat[row*4+col]) * acc_t'(q16_t'(v[col*32 +: 32]));
            sh = sum >>> `VTU_FRAC_BITS;
            if (sh > acc_t'(32'sh7FFF_FFFF))
                c = 32'h7FFF_FFFF;
            else if (sh < acc_t'(32'sh8000_0000))
                c = 32'h8000_0000;
            else
                c = sh[31:0];
            r[row*32 +: 32] = to_fp32(c);
        end
        return r;
    endfunction

    function automatic q16_t rand_q16(input int shift);
        return q16_t'($signed($urandom) >>> shift);
    endfunction

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axi_resp_t resp);
        int   cyc;
        int   stall;
        logic aw_done, w_done, b_seen;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b0;
        aw_done = 1'b0;
        w_done = 1'b0;
        b_seen = 1'b0;
        resp = 2'bxx;
        // Hold off bready for a few cycles once the response is up
        stall = int'($urandom_range(3, 0));
        cyc = 0;
        while (!(aw_done && w_done) && cyc < TIMEOUT) begin
            @(negedge aclk);
            aw_done = aw_done | (awvalid & awready);
            w_done = w_done | (wvalid & wready);
            @(posedge aclk);
            #DRV_DLY;
            awvalid = awvalid & !aw_done;
            wvalid = wvalid & !w_done;
            cyc++;
        end
        if (!(aw_done && w_done))
            note_timeout("AXI4-Lite address or data handshake");
        cyc = 0;
        while (!b_seen && cyc < TIMEOUT) begin
            @(negedge aclk);
            b_seen = bvalid & bready;
            resp = bresp;
            @(posedge aclk);
            #DRV_DLY;
            if (bvalid && !b_seen) begin
                if (stall == 0)
                    bready = 1'b1;
                else
                    stall--;
            end
            cyc++;
        end
        if (!b_seen)
            note_timeout("AXI4-Lite write response");
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
    endtask

    task automatic load_matrix();
        axi_resp_t resp;
        for (int i = 0; i < 16; i++) begin
            axil_write(axil_addr_t'(i * 4), mat[i], resp);
            check_resp($sformatf("bresp word %0d", i), resp, resp_okay);
        end
    endtask

    task automatic send_beat(input vec_t v, input logic last, input vec_t exp);
        int   cyc;
        logic took;
        exp_data_q.push_back(exp);
        exp_last_q.push_back(last);
        s_tdata = v;
        s_tlast = last;
        s_tvalid = 1'b1;
        took = 1'b0;
        cyc = 0;
        while (!took && cyc < TIMEOUT) begin
            @(negedge aclk);
            took = s_tready;
            @(posedge aclk);
            cyc++;
        end
        if (!took)
            note_timeout("input stream tready");
        #DRV_DLY;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
    endtask

    task automatic drain_compare();
        int   cyc;
        vec_t got_v, exp_v;
        logic got_l, exp_l;
        cyc = 0;
        while (got_data_q.size() < exp_data_q.size() && cyc < TIMEOUT) begin
            @(posedge aclk);
            cyc++;
        end
        if (got_data_q.size() < exp_data_q.size())
            note_timeout("output beat for every vector sent");
        // Leave room for a stray extra beat
        repeat (8) @(posedge aclk);
        #DRV_DLY;
        if (got_data_q.size() > exp_data_q.size()) begin
            $display("Output stream gave %0d beats for %0d vectors",
                     got_data_q.size(), exp_data_q.size());
            err_cnt++;
        end
        while (exp_data_q.size() > 0 && got_data_q.size() > 0) begin
            got_v = got_data_q.pop_front();
            exp_v = exp_data_q.pop_front();
            got_l = got_last_q.pop_front();
            exp_l = exp_last_q.pop_front();
            for (int c = 0; c < 4; c++)
                check_fp32($sformatf("m_axis_tdata[%0d]", c), got_v[c*32 +: 32],
                           exp_v[c*32 +: 32]);
            check_last("m_axis_tlast", got_l, exp_l);
        end
        exp_data_q.delete();
        exp_last_q.delete();
        got_data_q.delete();
        got_last_q.delete();
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            fail_cnt++;
            $display("[%0t] %s: %0d errors", $time, name, err_cnt - errs_before);
        end
    endtask

    task automatic identity_transform();
        int   errs;
        vec_t v, e;
        errs = err_cnt;
        for (int i = 0; i < 16; i++)
            mat[i] = (i % 5 == 0) ? 32'sh0001_0000 : '0;
        load_matrix();
        for (int n = 0; n < 8; n++) begin
            for (int c = 0; c < 4; c++) begin
                v[c*32 +: 32] = rand_q16(8);
                e[c*32 +: 32] = to_fp32(v[c*32 +: 32]);
            end
            send_beat(v, n == 7, e);
        end
        drain_compare();
        end_test("identity matrix", errs);
    endtask

    task automatic random_transform();
        int   errs;
        vec_t v;
        errs = err_cnt;
        for (int i = 0; i < 16; i++)
            mat[i] = rand_q16(12);
        load_matrix();
        for (int n = 0; n < 12; n++) begin
            for (int c = 0; c < 4; c++)
                v[c*32 +: 32] = rand_q16(10);
            send_beat(v, n == 11, model_out(v));
        end
        drain_compare();
        end_test("general transform", errs);
    endtask

    task automatic saturate_row_sums();
        int errs;
        errs = err_cnt;
        // Rows 0 and 2 large positive and rows 1 and 3 most negative
        for (int i = 0; i < 16; i++)
            mat[i] = ((i / 4) % 2 == 0) ? 32'sh7FFF_0000 : 32'sh8000_0000;
        load_matrix();
        send_beat({4{32'h7FFF_0000}}, 1'b0,
                  {32'hC700_0000, 32'h46FF_FFFF, 32'hC700_0000, 32'h46FF_FFFF});
        send_beat({4{32'h8001_0000}}, 1'b1,
                  {32'h46FF_FFFF, 32'hC700_0000, 32'h46FF_FFFF, 32'hC700_0000});
        drain_compare();
        end_test("saturation", errs);
    endtask

    task automatic sweep_address_map();
        int        errs;
        axi_resp_t resp;
        vec_t      v;
        errs = err_cnt;
        for (int i = 0; i < 16; i++)
            mat[i] = rand_q16(12);
        load_matrix();
        // No 6-bit address reaches word 16, so every byte address answers OKAY
        for (int a = 0; a < 64; a++) begin
            axil_write(axil_addr_t'(a), mat[a >> 2], resp);
            check_resp($sformatf("bresp addr 0x%02h", a), resp, resp_okay);
        end
        v = {32'hFFFF_0000, 32'h0003_8000, 32'hFFFE_4000, 32'h0001_0000};
        send_beat(v, 1'b1, model_out(v));
        drain_compare();
        end_test("address map", errs);
    endtask

    task automatic stall_output_stream();
        int   errs;
        vec_t v;
        errs = err_cnt;
        for (int i = 0; i < 16; i++)
            mat[i] = rand_q16(12);
        load_matrix();
        stall_en = 1'b1;
        for (int n = 0; n < 20; n++) begin
            for (int c = 0; c < 4; c++)
                v[c*32 +: 32] = rand_q16(10);
            send_beat(v, n == 19, model_out(v));
        end
        drain_compare();
        stall_en = 1'b0;
        end_test("back-pressure and tlast", errs);
    endtask

    initial begin
        void'($urandom(SEED));
        aresetn = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        s_tdata = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        m_tready = 1'b1;
        stall_en = 1'b0;
        err_cnt = 0;
        test_cnt = 0;
        fail_cnt = 0;
        repeat (4) @(posedge aclk);
        #DRV_DLY;
        aresetn = 1'b1;
        identity_transform();
        random_transform();
        saturate_row_sums();
        sweep_address_map();
        stall_output_stream();
        err_cnt += int'(DUT.u_stream_chk.fail_count);
        $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
                 test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- vertex_transform_unit.f
+incdir+hw
hw/vtu_pkg.sv
hw/vtu_fixed_to_fp32.sv
hw/vtu_matrix_regs.sv
hw/vtu_mac_array.sv
hw/vtu_output_stages.sv
hw/vertex_transform_unit.sv
bench/vtu_stream_chk.sv
bench/tb_vertex_transform_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vertex transform unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_vertex_transform_unit \
    -f vertex_transform_unit.f -o vtu_sim || exit 1
result=$(./obj_dir/vtu_sim +verilator+error+limit+1000)
echo "$result"
echo "$result" | grep -q "All tests passed" && echo "run_sim: PASS" || {
    echo "run_sim: FAIL"
    exit 1
}
